// File: design/banked_mem.sv
/*
 * four-bank interleaved backing memory
 * banks selected by word offset, each busy for a few cycles per access,
 * read data returned through a fixed latency pipeline
 */
`timescale 1ns/1ps

module banked_mem (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic [mem_sys_pkg::addr_w-1:0]  mem_addr,
   input  logic [mem_sys_pkg::word_w-1:0]  mem_wdata,
   input  logic                            mem_rd,
   input  logic                            mem_wr,
   output logic [mem_sys_pkg::word_w-1:0]  mem_rdata,
   output logic                            mem_rvalid,
   output logic                            mem_stall
);

   localparam int busy_w = $clog2(mem_sys_pkg::bank_busy_cycles + 1);
   localparam int lat    = mem_sys_pkg::mem_read_latency;

   logic [mem_sys_pkg::word_w-1:0] store [mem_sys_pkg::mem_words];

   logic [busy_w-1:0]                bank_cnt [mem_sys_pkg::banks];
   logic [mem_sys_pkg::addr_w-2:0]   word_addr;
   logic [mem_sys_pkg::offset_w-1:0] bank;
   logic                             bank_busy;
   logic                             accept;

   logic [mem_sys_pkg::word_w-1:0] rdata_pipe [lat];
   logic [lat-1:0]                 rvalid_pipe;

   // the store powers up cleared
   initial begin
      for (int i = 0; i < mem_sys_pkg::mem_words; i++) begin
         store[i] = '0;
      end
   end

   assign word_addr = mem_addr[mem_sys_pkg::addr_w-1:1];
   assign bank      = mem_addr[mem_sys_pkg::offset_w:1];
   assign bank_busy = (bank_cnt[bank] != '0);
   assign mem_stall = (mem_rd | mem_wr) & bank_busy;
   assign accept    = (mem_rd | mem_wr) & ~bank_busy;

   // per-bank busy timers
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int b = 0; b < mem_sys_pkg::banks; b++) begin
            bank_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < mem_sys_pkg::banks; b++) begin
            if (accept && (bank == b)) begin
               bank_cnt[b] <= busy_w'(mem_sys_pkg::bank_busy_cycles);
            end else if (bank_cnt[b] != '0) begin
               bank_cnt[b] <= bank_cnt[b] - 1'b1;
            end
         end
      end
   end

   // word store and read data pipeline
   always_ff @(posedge clk) begin
      if (accept && mem_wr) begin
         store[word_addr] <= mem_wdata;
      end
      rdata_pipe[0] <= store[word_addr];
      for (int s = 1; s < lat; s++) begin
         rdata_pipe[s] <= rdata_pipe[s-1];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rvalid_pipe <= '0;
      end else begin
         rvalid_pipe <= {rvalid_pipe[lat-2:0], accept & mem_rd};
      end
   end

   assign mem_rdata  = rdata_pipe[lat-1];
   assign mem_rvalid = rvalid_pipe[lat-1];

endmodule

// File: design/cache_array.sv
/*
 * direct-mapped cache storage
 * per-line tag, valid and dirty bits plus four data words,
 * combinational tag compare and word read, writes at the clock edge
 */
`timescale 1ns/1ps

module cache_array (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic                               enable,
   input  logic                               comp,
   input  logic                               write,
   input  logic [mem_sys_pkg::tag_w-1:0]      tag_in,
   input  logic [mem_sys_pkg::index_w-1:0]    index,
   input  logic [mem_sys_pkg::offset_w-1:0]   offset,
   input  logic [mem_sys_pkg::word_w-1:0]     data_in,
   output logic [mem_sys_pkg::tag_w-1:0]      tag_out,
   output logic [mem_sys_pkg::word_w-1:0]     data_out,
   output logic                               hit,
   output logic                               valid,
   output logic                               dirty
);

   localparam int last_word = mem_sys_pkg::words_per_line - 1;

   logic [mem_sys_pkg::tag_w-1:0]  tag_mem  [mem_sys_pkg::lines];
   logic [mem_sys_pkg::word_w-1:0] data_mem [mem_sys_pkg::lines][mem_sys_pkg::words_per_line];
   logic [mem_sys_pkg::lines-1:0]  valid_mem;
   logic [mem_sys_pkg::lines-1:0]  dirty_mem;

   logic tag_match;
   logic host_write;
   logic fill_write;

   // line lookup
   assign tag_out  = tag_mem[index];
   assign data_out = data_mem[index][offset];
   assign valid    = valid_mem[index];
   assign dirty    = dirty_mem[index];

   assign tag_match = (tag_mem[index] == tag_in);
   assign hit       = enable & comp & valid_mem[index] & tag_match;

   // host stores only land on a hit, fill stores go in unconditionally
   assign host_write = enable & write & comp & hit;
   assign fill_write = enable & write & ~comp;

   // tag and data arrays
   always_ff @(posedge clk) begin
      if (host_write || fill_write) begin
         data_mem[index][offset] <= data_in;
      end
      if (fill_write) begin
         tag_mem[index] <= tag_in;
      end
   end

   // line state bits
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_mem <= '0;
         dirty_mem <= '0;
      end else begin
         if (host_write) begin
            dirty_mem[index] <= 1'b1;
         end else if (fill_write) begin
            dirty_mem[index] <= 1'b0;
            // line becomes usable once its last word has arrived
            if (offset == last_word) begin
               valid_mem[index] <= 1'b1;
            end
         end
      end
   end

endmodule

// File: design/cache_ctrl.sv
/*
 * cache controller FSM
 * compare, dirty line writeback, overlapped line fill and recompare
 */
`timescale 1ns/1ps

module cache_ctrl (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic                               rd,
   input  logic                               wr,
   input  logic                               addr_lsb,
   input  logic                               hit,
   input  logic                               valid,
   input  logic                               dirty,
   input  logic                               mem_stall,
   input  logic                               mem_rvalid,
   output logic                               comp,
   output logic                               write,
   output logic                               enable,
   output logic [mem_sys_pkg::offset_w-1:0]   line_offset,
   output logic [mem_sys_pkg::offset_w-1:0]   mem_offset,
   output logic                               wb_phase,
   output logic                               mem_rd,
   output logic                               mem_wr,
   output logic                               done,
   output logic                               stall,
   output logic                               cache_hit,
   output logic                               err
);

   localparam int last_word = mem_sys_pkg::words_per_line - 1;

   typedef enum logic [1:0] {
      st_idle,
      st_wb,
      st_fill,
      st_recomp
   } state_t;

   state_t state;
   state_t state_nxt;

   // issue count has one extra bit to flag that the whole line is requested
   logic [mem_sys_pkg::offset_w:0]   issue_cnt;
   logic [mem_sys_pkg::offset_w:0]   issue_cnt_nxt;
   logic [mem_sys_pkg::offset_w-1:0] ret_cnt;
   logic [mem_sys_pkg::offset_w-1:0] ret_cnt_nxt;

   logic req;
   logic bad_req;

   assign req     = rd | wr;
   assign bad_req = (rd & wr) | addr_lsb;

   assign wb_phase    = (state == st_wb);
   assign mem_offset  = issue_cnt[mem_sys_pkg::offset_w-1:0];
   assign line_offset = wb_phase ? issue_cnt[mem_sys_pkg::offset_w-1:0] : ret_cnt;

   // outputs to cache, memory and host
   always_comb begin
      comp      = 1'b0;
      write     = 1'b0;
      enable    = 1'b0;
      mem_rd    = 1'b0;
      mem_wr    = 1'b0;
      done      = 1'b0;
      stall     = 1'b0;
      cache_hit = 1'b0;
      err       = 1'b0;
      case (state)
         st_idle: begin
            if (req && bad_req) begin
               err = 1'b1;
            end else if (req) begin
               comp   = 1'b1;
               enable = 1'b1;
               write  = wr;
               if (hit) begin
                  done      = 1'b1;
                  cache_hit = 1'b1;
               end else begin
                  stall = 1'b1;
               end
            end
         end
         st_wb: begin
            // read old word out of the cache straight into the memory
            enable = 1'b1;
            mem_wr = 1'b1;
            stall  = 1'b1;
         end
         st_fill: begin
            mem_rd = ~issue_cnt[mem_sys_pkg::offset_w];
            enable = mem_rvalid;
            write  = mem_rvalid;
            stall  = 1'b1;
         end
         st_recomp: begin
            // line is resident now, so this compare always hits
            comp   = 1'b1;
            enable = 1'b1;
            write  = wr;
            done   = 1'b1;
         end
         default: begin
         end
      endcase
   end

   // next state and counters
   always_comb begin
      state_nxt     = state;
      issue_cnt_nxt = issue_cnt;
      ret_cnt_nxt   = ret_cnt;
      case (state)
         st_idle: begin
            issue_cnt_nxt = '0;
            ret_cnt_nxt   = '0;
            if (req && !bad_req && !hit) begin
               state_nxt = (valid && dirty) ? st_wb : st_fill;
            end
         end
         st_wb: begin
            if (!mem_stall) begin
               if (issue_cnt == last_word) begin
                  issue_cnt_nxt = '0;
                  state_nxt     = st_fill;
               end else begin
                  issue_cnt_nxt = issue_cnt + 1'b1;
               end
            end
         end
         st_fill: begin
            if (mem_rd && !mem_stall) begin
               issue_cnt_nxt = issue_cnt + 1'b1;
            end
            if (mem_rvalid) begin
               ret_cnt_nxt = ret_cnt + 1'b1;
               if (ret_cnt == last_word) begin
                  state_nxt = st_recomp;
               end
            end
         end
         st_recomp: begin
            state_nxt = st_idle;
         end
         default: begin
            state_nxt = st_idle;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= st_idle;
         issue_cnt <= '0;
         ret_cnt   <= '0;
      end else begin
         state     <= state_nxt;
         issue_cnt <= issue_cnt_nxt;
         ret_cnt   <= ret_cnt_nxt;
      end
   end

endmodule

// File: design/mem_sys_pkg.sv
/*
 * memory system package
 * address field widths, cache geometry and backing memory timing
 */
package mem_sys_pkg;

   // data word and byte address
   localparam int word_w = 16;
   localparam int addr_w = 16;

   // address split: tag | index | word offset | byte bit
   localparam int tag_w = 5;
   localparam int index_w = 8;
   localparam int offset_w = 2;

   // cache geometry
   localparam int lines = 256;
   localparam int words_per_line = 4;

   // backing memory, one bank per word offset
   localparam int banks = 4;
   localparam int bank_busy_cycles = 4;
   localparam int mem_read_latency = 2;
   localparam int mem_words = 32768;

endpackage

// File: design/mem_system.sv
/*
 * cached memory system top level
 * steers addresses and data between host, cache and banked memory
 */
`timescale 1ns/1ps

module mem_system (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic [mem_sys_pkg::addr_w-1:0]  addr,
   input  logic [mem_sys_pkg::word_w-1:0]  wdata,
   input  logic                            rd,
   input  logic                            wr,
   output logic [mem_sys_pkg::word_w-1:0]  rdata,
   output logic                            done,
   output logic                            stall,
   output logic                            cache_hit,
   output logic                            err
);

   localparam int tag_w    = mem_sys_pkg::tag_w;
   localparam int index_w  = mem_sys_pkg::index_w;
   localparam int offset_w = mem_sys_pkg::offset_w;

   // host address fields
   logic [tag_w-1:0]    host_tag;
   logic [index_w-1:0]  host_index;
   logic [offset_w-1:0] host_offset;

   logic comp, write, enable, wb_phase;
   logic hit, valid, dirty;
   logic [offset_w-1:0] line_offset;
   logic [offset_w-1:0] mem_offset;
   logic [offset_w-1:0] cache_offset;
   logic [tag_w-1:0]    tag_out;
   logic [mem_sys_pkg::word_w-1:0] cache_wdata;
   logic [mem_sys_pkg::word_w-1:0] cache_rdata;

   logic mem_rd, mem_wr, mem_stall, mem_rvalid;
   logic [mem_sys_pkg::addr_w-1:0] mem_addr;
   logic [mem_sys_pkg::word_w-1:0] mem_rdata;

   assign host_tag    = addr[mem_sys_pkg::addr_w-1 -: tag_w];
   assign host_index  = addr[offset_w+1 +: index_w];
   assign host_offset = addr[1 +: offset_w];

   // host offset on compare, controller offset while servicing a miss
   assign cache_offset = comp ? host_offset : line_offset;
   assign cache_wdata  = comp ? wdata : mem_rdata;

   // victim line address on writeback, requested line on fill
   assign mem_addr = wb_phase ? {tag_out, host_index, mem_offset, 1'b0}
                              : {host_tag, host_index, mem_offset, 1'b0};

   assign rdata = cache_rdata;

   cache_ctrl u_ctrl (
      .clk         (clk),
      .rst_n       (rst_n),
      .rd          (rd),
      .wr          (wr),
      .addr_lsb    (addr[0]),
      .hit         (hit),
      .valid       (valid),
      .dirty       (dirty),
      .mem_stall   (mem_stall),
      .mem_rvalid  (mem_rvalid),
      .comp        (comp),
      .write       (write),
      .enable      (enable),
      .line_offset (line_offset),
      .mem_offset  (mem_offset),
      .wb_phase    (wb_phase),
      .mem_rd      (mem_rd),
      .mem_wr      (mem_wr),
      .done        (done),
      .stall       (stall),
      .cache_hit   (cache_hit),
      .err         (err)
   );

   cache_array u_cache (
      .clk      (clk),
      .rst_n    (rst_n),
      .enable   (enable),
      .comp     (comp),
      .write    (write),
      .tag_in   (host_tag),
      .index    (host_index),
      .offset   (cache_offset),
      .data_in  (cache_wdata),
      .tag_out  (tag_out),
      .data_out (cache_rdata),
      .hit      (hit),
      .valid    (valid),
      .dirty    (dirty)
   );

   banked_mem u_mem (
      .clk        (clk),
      .rst_n      (rst_n),
      .mem_addr   (mem_addr),
      .mem_wdata  (cache_rdata),
      .mem_rd     (mem_rd),
      .mem_wr     (mem_wr),
      .mem_rdata  (mem_rdata),
      .mem_rvalid (mem_rvalid),
      .mem_stall  (mem_stall)
   );

endmodule

// File: flist.f
design/mem_sys_pkg.sv
design/cache_array.sv
design/cache_ctrl.sv
design/banked_mem.sv
design/mem_system.sv
test/mem_system_tb.sv

// File: run.sh
#!/bin/sh
# build and run the cached memory system testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module mem_system_tb -f flist.f -o mem_system_sim

./obj_dir/mem_system_sim | tee sim.log

if grep -q "\*\* PASS \*\*" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// File: test/mem_system_tb.sv
/*
 * cached memory system testbench
 * directed and random host traffic checked by assertions
 * against a shadow word memory and a direct-mapped tag model
 */
`timescale 1ns/1ps

module mem_system_tb;

   localparam int directed_reqs = 12;
   localparam int random_reqs   = 300;
   localparam int cycle_limit   = 200 * (directed_reqs + random_reqs) + 50;

   logic        clk;
   logic        rst_n;
   logic [15:0] addr;
   logic [15:0] wdata;
   logic        rd;
   logic        wr;
   logic [15:0] rdata;
   logic        done;
   logic        stall;
   logic        cache_hit;
   logic        err;

   // reference models
   logic [mem_sys_pkg::word_w-1:0] shadow [mem_sys_pkg::mem_words];
   logic [mem_sys_pkg::tag_w-1:0]  tag_model [mem_sys_pkg::lines];
   logic [mem_sys_pkg::lines-1:0]  valid_model;
   logic [15:0] exp_word;
   logic        exp_hit;
   logic        req;
   logic        bad_req;
   logic        good_req;
   int          cycles = 0;

   mem_system uut (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (addr),
      .wdata     (wdata),
      .rd        (rd),
      .wr        (wr),
      .rdata     (rdata),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   assign exp_word = shadow[addr[15:1]];
   assign exp_hit  = valid_model[addr[10:3]] && (tag_model[addr[10:3]] == addr[15:11]);
   assign req      = rd | wr;
   assign bad_req  = req & ((rd & wr) | addr[0]);
   assign good_req = req & ~bad_req;

   task automatic stop_with(input string line);
      $display("%s", line);
      $display("** FAIL **");
      $fatal(1);
   endtask

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         stop_with($sformatf("timeout, requests did not finish within %0d cycles", cycle_limit));
      end
   end

   a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      !req |-> !done && !stall && !err && !cache_hit)
      else stop_with($sformatf("FAILED at %0t: outputs active with no request", $time));

   a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
      done && rd |-> rdata == exp_word)
      else stop_with($sformatf("FAILED at %0t: read of %h returned %h, expected %h",
                               $time, $sampled(addr), $sampled(rdata), $sampled(exp_word)));

   a_hit_model: assert property (@(posedge clk) disable iff (!rst_n)
      done |-> cache_hit == exp_hit)
      else stop_with($sformatf("FAILED at %0t: cache_hit %b, tag model says %b",
                               $time, $sampled(cache_hit), $sampled(exp_hit)));

   a_hit_with_done: assert property (@(posedge clk) disable iff (!rst_n)
      cache_hit |-> done)
      else stop_with($sformatf("FAILED at %0t: cache_hit without done", $time));

   a_miss_stalls: assert property (@(posedge clk) disable iff (!rst_n)
      good_req && !done |-> stall)
      else stop_with($sformatf("FAILED at %0t: pending miss without stall", $time));

   a_stall_no_done: assert property (@(posedge clk) disable iff (!rst_n)
      stall |-> !done)
      else stop_with($sformatf("FAILED at %0t: done during stall", $time));

   a_miss_done: assert property (@(posedge clk) disable iff (!rst_n)
      done && !cache_hit |-> $past(stall))
      else stop_with($sformatf("FAILED at %0t: miss completed without prior stall", $time));

   a_err_on_bad: assert property (@(posedge clk) disable iff (!rst_n)
      bad_req |-> err && !done)
      else stop_with($sformatf("FAILED at %0t: bad request gave err %b done %b",
                               $time, $sampled(err), $sampled(done)));

   a_err_only_bad: assert property (@(posedge clk) disable iff (!rst_n)
      err |-> bad_req)
      else stop_with($sformatf("FAILED at %0t: err on a well-formed request", $time));

   // present one request and hold it until done or err
   task automatic run_request(input logic do_rd, input logic do_wr,
                              input logic [15:0] a, input logic [15:0] d);
      logic finished;
      logic completed;
      addr      = a;
      wdata     = d;
      rd        = do_rd;
      wr        = do_wr;
      finished  = 1'b0;
      completed = 1'b0;
      while (!finished) begin
         @(negedge clk);
         finished  = done || err;
         completed = done;
      end
      @(posedge clk);
      #1;
      if (completed) begin
         if (do_wr) begin
            shadow[a[15:1]] = d;
         end
         tag_model[a[10:3]]   = a[15:11];
         valid_model[a[10:3]] = 1'b1;
      end
      rd = 1'b0;
      wr = 1'b0;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   initial begin
      logic [4:0]  tag;
      logic [7:0]  idx;
      logic [1:0]  off;
      logic [15:0] a;
      int          kind;
      rst_n       = 1'b0;
      addr        = '0;
      wdata       = '0;
      rd          = 1'b0;
      wr          = 1'b0;
      valid_model = '0;
      void'($urandom(32'h44c2));
      for (int i = 0; i < mem_sys_pkg::mem_words; i++) begin
         shadow[i] = '0;
      end
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
      idle_cycles(4);

      // cold miss, then hit on the same line
      run_request(1'b1, 1'b0, 16'h0000, 16'h0000);
      run_request(1'b1, 1'b0, 16'h0000, 16'h0000);
      // dirty the line, evict it with a conflicting tag, read it back
      run_request(1'b0, 1'b1, 16'h0002, 16'hbeef);
      run_request(1'b1, 1'b0, 16'h0802, 16'h0000);
      run_request(1'b1, 1'b0, 16'h0002, 16'h0000);
      // malformed requests leave everything as it was
      run_request(1'b1, 1'b1, 16'h0004, 16'h1234);
      run_request(1'b1, 1'b0, 16'h0003, 16'h0000);
      run_request(1'b0, 1'b1, 16'h0005, 16'h5678);
      run_request(1'b1, 1'b0, 16'h0004, 16'h0000);
      // write miss allocates, then eviction writes it back
      run_request(1'b0, 1'b1, 16'h0806, 16'ha5c3);
      run_request(1'b1, 1'b0, 16'h0006, 16'h0000);
      run_request(1'b1, 1'b0, 16'h0806, 16'h0000);
      idle_cycles(3);

      // random traffic on a few indices so conflicts are frequent
      for (int n = 0; n < random_reqs; n++) begin
         tag = 5'($urandom % 4);
         case ($urandom % 4)
            0: idx = 8'h00;
            1: idx = 8'h01;
            2: idx = 8'h80;
            default: idx = 8'hff;
         endcase
         off  = 2'($urandom % 4);
         a    = {tag, idx, off, 1'b0};
         kind = int'($urandom % 20);
         if (kind == 0) begin
            run_request(1'b1, 1'b1, a, 16'($urandom));
         end else if (kind == 1) begin
            run_request(1'b1, 1'b0, a | 16'h0001, 16'h0000);
         end else if (kind < 11) begin
            run_request(1'b0, 1'b1, a, 16'($urandom));
         end else begin
            run_request(1'b1, 1'b0, a, 16'h0000);
         end
         if ($urandom % 8 == 0) begin
            idle_cycles(1 + int'($urandom % 3));
         end
      end

      idle_cycles(4);
      $display("** PASS **");
      $finish;
   end

endmodule
